/* src/cache_pkg.sv */
`default_nettype none

package cache_pkg;

    ////////////////////////////////////////////////////////////
    // geometry
    ////////////////////////////////////////////////////////////

    localparam int num_ways    = 4;
    localparam int num_sets    = 16;
    localparam int byte_bits   = 2;   // byte within word
    localparam int offset_bits = 3;   // word within line
    localparam int set_bits    = 4;
    localparam int tag_bits    = 23;  // addr[31:9]

    typedef logic [1:0]             way_t;
    typedef logic [set_bits-1:0]    set_t;
    typedef logic [tag_bits-1:0]    tag_t;
    typedef logic [offset_bits-1:0] offset_t;
    typedef logic [31:0]            word_t;
    typedef logic [255:0]           line_t;   // word k at bits 32k upward

    // tree plru, bit 0 picks the pair, bit 1 inside ways 0-1, bit 2 inside ways 2-3
    typedef logic [2:0]             plru_t;

    typedef enum logic [1:0] {
        compare,
        readmem,
        fill
    } ctrl_state_t;

endpackage

`default_nettype wire

/* src/cache_array.sv */
`timescale 1ns/1ps
`default_nettype none

// single-port sync ram, one entry per set
module cache_array #(
    parameter type entry_t = logic,
    parameter int  depth   = cache_pkg::num_sets
) (
    input  logic              clk,
    input  logic              en,
    input  logic              we,
    input  cache_pkg::set_t   addr,
    input  entry_t            wdata,
    output entry_t            rdata
);

    entry_t mem [depth];

    always_ff @(posedge clk) begin
        if (en) begin
            if (we) begin
                mem[addr] <= wdata;
                rdata     <= wdata;      // write-first, refill shows up on the re-read
            end else begin
                rdata     <= mem[addr];
            end
        end
    end

endmodule

`default_nettype wire

/* src/cache_way.sv */
`timescale 1ns/1ps
`default_nettype none

module cache_way #(
    parameter int way_idx = 0
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              rd_en,
    input  cache_pkg::set_t   rd_set,
    input  cache_pkg::tag_t   cur_tag,
    input  logic              fill_en,
    input  cache_pkg::way_t   fill_way,
    input  cache_pkg::set_t   fill_set,
    input  cache_pkg::tag_t   fill_tag,
    input  cache_pkg::line_t  fill_line,
    output logic              hit,
    output cache_pkg::line_t  line
);

    logic                           wr;
    logic                           arr_en;
    cache_pkg::set_t                arr_addr;
    cache_pkg::tag_t                tag_q;
    logic [cache_pkg::num_sets-1:0] valid;
    logic                           valid_q;

    assign wr       = fill_en && (fill_way == cache_pkg::way_t'(way_idx));  // only our way
    assign arr_en   = rd_en || wr;
    assign arr_addr = wr ? fill_set : rd_set;

    cache_array #(
        .entry_t (cache_pkg::tag_t)
    ) u_tag (
        .clk   (clk),
        .en    (arr_en),
        .we    (wr),
        .addr  (arr_addr),
        .wdata (fill_tag),
        .rdata (tag_q)
    );

    cache_array #(
        .entry_t (cache_pkg::line_t)
    ) u_line (
        .clk   (clk),
        .en    (arr_en),
        .we    (wr),
        .addr  (arr_addr),
        .wdata (fill_line),
        .rdata (line)
    );

    ////////////////////////////////////////////////////////////
    // valid bits
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            valid   <= '0;
            valid_q <= 1'b0;
        end else begin
            if (wr) begin
                valid[fill_set] <= 1'b1;
            end
            if (arr_en) begin
                valid_q <= wr ? 1'b1 : valid[rd_set];
            end
        end
    end

    assign hit = valid_q && (tag_q == cur_tag);

    // refill and its re-read share one set, else the shared ram port would split
    a_fill_rd_same_set: assert property (@(posedge clk) disable iff (rst)
        (fill_en && rd_en) |-> (fill_set == rd_set));

endmodule

`default_nettype wire

/* src/cache_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module cache_ctrl (
    input  logic                clk,
    input  logic                rst,

    // cpu side
    input  logic [31:0]         addr,
    input  logic [3:0]          rmask,
    output logic                resp,

    // memory side
    output logic [31:0]         dfp_addr,
    output logic                dfp_read,
    input  cache_pkg::line_t    dfp_rdata,
    input  logic                dfp_resp,

    // broadcast to the ways
    output logic                rd_en,
    output cache_pkg::set_t     rd_set,
    output cache_pkg::tag_t     cur_tag,
    output logic                fill_en,
    output cache_pkg::way_t     fill_way,
    output cache_pkg::set_t     fill_set,
    output cache_pkg::tag_t     fill_tag,
    output cache_pkg::line_t    fill_line,

    // hit / lru unit
    output logic                cur_req,
    output cache_pkg::set_t     cur_set,
    output cache_pkg::offset_t  cur_offset,
    input  logic                any_hit,
    input  cache_pkg::way_t     victim
);

    localparam int set_lsb = cache_pkg::byte_bits + cache_pkg::offset_bits;

    ////////////////////////////////////////////////////////////
    // decode
    ////////////////////////////////////////////////////////////

    logic                   req_open;
    cache_pkg::set_t        next_set;
    cache_pkg::tag_t        next_tag;
    cache_pkg::offset_t     next_offset;

    assign req_open    = |rmask;
    assign next_offset = addr[cache_pkg::byte_bits +: cache_pkg::offset_bits];
    assign next_set    = addr[set_lsb +: cache_pkg::set_bits];
    assign next_tag    = addr[31 -: cache_pkg::tag_bits];

    ////////////////////////////////////////////////////////////
    // stage register
    ////////////////////////////////////////////////////////////

    cache_pkg::ctrl_state_t state, state_next;
    logic                   load;
    logic                   miss;
    cache_pkg::line_t       line_q;

    // take a new request when nothing is pending or the current one is answered
    assign load = (state == cache_pkg::compare) && (!cur_req || resp);

    always_ff @(posedge clk) begin
        if (rst) begin
            cur_req <= 1'b0;
        end else if (load) begin
            cur_req <= req_open;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            cur_set    <= next_set;
            cur_tag    <= next_tag;
            cur_offset <= next_offset;
        end
        if (dfp_resp) begin
            line_q <= dfp_rdata;            // held for the write in the fill cycle
        end
    end

    ////////////////////////////////////////////////////////////
    // fsm
    ////////////////////////////////////////////////////////////

    assign miss = (state == cache_pkg::compare) && cur_req && !any_hit;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= cache_pkg::compare;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        unique case (state)
            cache_pkg::compare: if (miss) state_next = cache_pkg::readmem;
            cache_pkg::readmem: if (dfp_resp) state_next = cache_pkg::fill;
            cache_pkg::fill:    state_next = cache_pkg::compare;
            default:            state_next = cache_pkg::compare;
        endcase
    end

    assign resp = (state == cache_pkg::compare) && cur_req && any_hit;

    // memory request
    assign dfp_read = miss || (state == cache_pkg::readmem);
    assign dfp_addr = {cur_tag, cur_set, {set_lsb{1'b0}}};  // line aligned

    // fill writes the victim and re-reads its own set
    assign fill_en   = (state == cache_pkg::fill);
    assign rd_en     = (load && req_open) || fill_en;
    assign rd_set    = load ? next_set : cur_set;
    assign fill_way  = victim;
    assign fill_set  = cur_set;
    assign fill_tag  = cur_tag;
    assign fill_line = line_q;

    a_dfp_read_hold: assert property (@(posedge clk) disable iff (rst)
        (dfp_read && !dfp_resp) |=> dfp_read);

    // every response follows an array read one cycle earlier
    a_resp_after_read: assert property (@(posedge clk) disable iff (rst)
        resp |-> $past(rd_en));

endmodule

`default_nettype wire

/* src/cache_hit_lru.sv */
`timescale 1ns/1ps
`default_nettype none

module cache_hit_lru (
    input  logic                clk,
    input  logic                rst,
    input  logic                way_hit [cache_pkg::num_ways],
    input  cache_pkg::line_t    way_line [cache_pkg::num_ways],
    input  logic                cur_req,
    input  cache_pkg::set_t     cur_set,
    input  cache_pkg::offset_t  cur_offset,
    input  cache_pkg::set_t     lru_rd_set,
    input  logic                resp,
    output logic                any_hit,
    output cache_pkg::way_t     victim,
    output logic [31:0]         rdata
);

    cache_pkg::way_t    hit_way;
    logic               hit_or;
    cache_pkg::plru_t   plru [cache_pkg::num_sets];
    cache_pkg::plru_t   plru_q;
    cache_pkg::plru_t   plru_upd;

    ////////////////////////////////////////////////////////////
    // hit merge and word select
    ////////////////////////////////////////////////////////////

    always_comb begin
        hit_or  = 1'b0;
        hit_way = '0;
        for (int w = 0; w < cache_pkg::num_ways; w++) begin
            if (way_hit[w]) begin
                hit_or  = 1'b1;
                hit_way = cache_pkg::way_t'(w);
            end
        end
    end

    assign any_hit = cur_req && hit_or;
    assign rdata   = way_line[hit_way][32*cur_offset +: 32];

    ////////////////////////////////////////////////////////////
    // plru state
    ////////////////////////////////////////////////////////////

    // point away from the way just used
    always_comb begin
        plru_upd = plru[cur_set];
        if (!hit_way[1]) begin
            plru_upd[0] = 1'b1;
            plru_upd[1] = !hit_way[0];
        end else begin
            plru_upd[0] = 1'b0;
            plru_upd[2] = !hit_way[0];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < cache_pkg::num_sets; s++) begin
                plru[s] <= '0;
            end
            plru_q <= '0;
        end else begin
            if (resp) begin
                plru[cur_set] <= plru_upd;
            end
            plru_q <= plru[lru_rd_set];  // tracks cur_set while a miss waits
        end
    end

    // walk from the root
    assign victim = plru_q[0] ? {1'b1, plru_q[2]} : {1'b0, plru_q[1]};

    a_onehot_hit: assert property (@(posedge clk) disable iff (rst)
        cur_req |-> $onehot0({way_hit[3], way_hit[2], way_hit[1], way_hit[0]}));

endmodule

`default_nettype wire

/* src/cache_top.sv */
`timescale 1ns/1ps
`default_nettype none

module cache_top (
    input  logic                clk,
    input  logic                rst,
    input  logic [31:0]         addr,
    input  logic [3:0]          rmask,
    output logic [31:0]         rdata,
    output logic                resp,
    output logic [31:0]         dfp_addr,
    output logic                dfp_read,
    input  cache_pkg::line_t    dfp_rdata,
    input  logic                dfp_resp
);

    logic                   rd_en;
    cache_pkg::set_t        rd_set;
    cache_pkg::tag_t        cur_tag;
    logic                   fill_en;
    cache_pkg::way_t        fill_way;
    cache_pkg::set_t        fill_set;
    cache_pkg::tag_t        fill_tag;
    cache_pkg::line_t       fill_line;
    logic                   cur_req;
    cache_pkg::set_t        cur_set;
    cache_pkg::offset_t     cur_offset;
    logic                   any_hit;
    cache_pkg::way_t        victim;
    logic                   way_hit  [cache_pkg::num_ways];
    cache_pkg::line_t       way_line [cache_pkg::num_ways];

    cache_ctrl u_ctrl (
        .clk        (clk),
        .rst        (rst),
        .addr       (addr),
        .rmask      (rmask),
        .resp       (resp),
        .dfp_addr   (dfp_addr),
        .dfp_read   (dfp_read),
        .dfp_rdata  (dfp_rdata),
        .dfp_resp   (dfp_resp),
        .rd_en      (rd_en),
        .rd_set     (rd_set),
        .cur_tag    (cur_tag),
        .fill_en    (fill_en),
        .fill_way   (fill_way),
        .fill_set   (fill_set),
        .fill_tag   (fill_tag),
        .fill_line  (fill_line),
        .cur_req    (cur_req),
        .cur_set    (cur_set),
        .cur_offset (cur_offset),
        .any_hit    (any_hit),
        .victim     (victim)
    );

    for (genvar w = 0; w < cache_pkg::num_ways; w++) begin : g_way
        cache_way #(
            .way_idx (w)
        ) u_way (
            .clk       (clk),
            .rst       (rst),
            .rd_en     (rd_en),
            .rd_set    (rd_set),
            .cur_tag   (cur_tag),
            .fill_en   (fill_en),
            .fill_way  (fill_way),
            .fill_set  (fill_set),
            .fill_tag  (fill_tag),
            .fill_line (fill_line),
            .hit       (way_hit[w]),
            .line      (way_line[w])
        );
    end

    cache_hit_lru u_hit_lru (
        .clk        (clk),
        .rst        (rst),
        .way_hit    (way_hit),
        .way_line   (way_line),
        .cur_req    (cur_req),
        .cur_set    (cur_set),
        .cur_offset (cur_offset),
        .lru_rd_set (rd_set),       // plru read follows the array read
        .resp       (resp),
        .any_hit    (any_hit),
        .victim     (victim),
        .rdata      (rdata)
    );

endmodule

`default_nettype wire

/* tests/mem_model.sv */
`timescale 1ns/1ps
`default_nettype none

// line memory behind the cache, one read at a time
module mem_model (
    input  logic              clk,
    input  logic              rst,
    input  logic [31:0]       dfp_addr,
    input  logic              dfp_read,
    output cache_pkg::line_t  dfp_rdata,
    output logic              dfp_resp
);

    logic [31:0] lfsr_state;

    function automatic logic [31:0] galois_step(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h8020_0003;   // x^32 + x^22 + x^2 + x + 1
        end else begin
            return s >> 1;
        end
    endfunction

    // word k of line A holds (A + 4k) xor a fixed pattern
    function automatic cache_pkg::line_t line_contents(input logic [31:0] line_addr);
        cache_pkg::line_t l;
        for (int k = 0; k < 8; k++) begin
            l[32*k +: 32] = (line_addr + 32'(4 * k)) ^ 32'h5a5a_c3c3;
        end
        return l;
    endfunction

    // 1 to 8 cycles, three lfsr bits
    task automatic next_latency(output int lat);
        lat = 1;
        for (int b = 0; b < 3; b++) begin
            lat = lat + (int'(lfsr_state[0]) << b);
            lfsr_state = galois_step(lfsr_state);
        end
    endtask

    initial begin
        logic [31:0] req_addr;
        int          lat;
        dfp_resp   = 1'b0;
        dfp_rdata  = '0;
        lfsr_state = 32'h893b_d095;
        forever begin
            @(negedge clk);                     // mid cycle, request is stable
            if (!rst && dfp_read) begin
                req_addr = dfp_addr;
                next_latency(lat);
                repeat (lat) @(posedge clk);
                #2;
                dfp_resp  = 1'b1;
                dfp_rdata = line_contents(req_addr);
                @(posedge clk);
                #2;
                dfp_resp  = 1'b0;               // single cycle pulse
                dfp_rdata = '0;
            end
        end
    end

endmodule

`default_nettype wire

/* tests/tb_cache.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_cache;

    logic                clk;
    logic                rst;
    logic [31:0]         addr;
    logic [3:0]          rmask;
    logic [31:0]         rdata;
    logic                resp;
    logic [31:0]         dfp_addr;
    logic                dfp_read;
    cache_pkg::line_t    dfp_rdata;
    logic                dfp_resp;

    // stimulus table, one entry per request
    logic [31:0]         row_addr  [$];
    logic [3:0]          row_rmask [$];
    logic                row_miss  [$];
    cache_pkg::word_t    row_word  [$];

    int                  cycle_count;
    int                  cycle_limit;

    cache_top u_dut (
        .clk       (clk),
        .rst       (rst),
        .addr      (addr),
        .rmask     (rmask),
        .rdata     (rdata),
        .resp      (resp),
        .dfp_addr  (dfp_addr),
        .dfp_read  (dfp_read),
        .dfp_rdata (dfp_rdata),
        .dfp_resp  (dfp_resp)
    );

    mem_model u_mem (
        .clk       (clk),
        .rst       (rst),
        .dfp_addr  (dfp_addr),
        .dfp_read  (dfp_read),
        .dfp_rdata (dfp_rdata),
        .dfp_resp  (dfp_resp)
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
            $display("timeout: the cache gave no response within %0d cycles", cycle_limit);
            $display("Test failed");
            $fatal(1, "run stopped by cycle limit");
        end
    end

    ////////////////////////////////////////////////////////////
    // compare tasks
    ////////////////////////////////////////////////////////////

    task automatic compare_word(input string name, input cache_pkg::word_t got,
                                input cache_pkg::word_t exp);
        if (got !== exp) begin
            $display("** Error: %s = %h, expected %h", name, got, exp);
            $display("Test failed");
            $fatal(1, "word mismatch");
        end
    endtask

    task automatic check_miss(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("** Error: %s = %h, expected %h", name, got, exp);
            $display("Test failed");
            $fatal(1, "miss mismatch");
        end
    endtask

    task automatic expect_latency(input string name, input int got, input int exp);
        if (got != exp) begin
            $display("** Error: %s = %0h, expected %0h", name, got, exp);
            $display("Test failed");
            $fatal(1, "latency mismatch");
        end
    endtask

    ////////////////////////////////////////////////////////////
    // table
    ////////////////////////////////////////////////////////////

    // expected word follows the memory pattern for the word address
    task automatic add_row(input logic [31:0] a, input logic [3:0] m, input logic miss);
        row_addr.push_back(a);
        row_rmask.push_back(m);
        row_miss.push_back(miss);
        row_word.push_back({a[31:2], 2'b00} ^ 32'h5a5a_c3c3);
    endtask

    task automatic build_table();
        add_row(32'h0000_1024, 4'hf, 1'b1);  // cold miss, set 1
        add_row(32'h0000_1020, 4'hf, 1'b0);  // hits stream back to back
        add_row(32'h0000_103c, 4'hf, 1'b0);
        add_row(32'h0000_1030, 4'hf, 1'b0);
        add_row(32'h0000_1028, 4'hf, 1'b0);
        add_row(32'h0000_2048, 4'hf, 1'b1);  // set 2
        add_row(32'h0000_2040, 4'hf, 1'b0);
        // set 3 fills ways 0, 2, 1, 3, plru back to 000
        add_row(32'h0001_0060, 4'hf, 1'b1);
        add_row(32'h0002_0064, 4'hf, 1'b1);
        add_row(32'h0003_0068, 4'hf, 1'b1);
        add_row(32'h0004_007c, 4'hf, 1'b1);
        // hit ways 2, 3, 0, 1 -> plru 001, victim way 2
        add_row(32'h0002_0070, 4'hf, 1'b0);
        add_row(32'h0004_0060, 4'hf, 1'b0);
        add_row(32'h0001_0074, 4'hf, 1'b0);
        add_row(32'h0003_006c, 4'hf, 1'b0);
        add_row(32'h0005_0060, 4'hf, 1'b1);  // evicts tag 2 from way 2
        add_row(32'h0001_0060, 4'hf, 1'b0);
        add_row(32'h0003_0060, 4'hf, 1'b0);
        add_row(32'h0004_0064, 4'hf, 1'b0);
        add_row(32'h0005_0078, 4'hf, 1'b0);  // plru 100, victim way 0
        // other sets, partial masks
        add_row(32'h0006_00a0, 4'h1, 1'b1);
        add_row(32'h0006_00ac, 4'h8, 1'b0);
        add_row(32'h0002_0080, 4'h3, 1'b1);  // same tag as evicted line, set 4
        add_row(32'h0000_0004, 4'h4, 1'b1);
        add_row(32'h0002_0060, 4'hf, 1'b1);  // evicted tag misses, lands in way 0
        add_row(32'h0003_0064, 4'hf, 1'b0);
        add_row(32'h0004_0068, 4'h2, 1'b0);
        add_row(32'h0005_0070, 4'hf, 1'b0);
        add_row(32'h0002_007c, 4'hf, 1'b0);
        add_row(32'h0001_0060, 4'hf, 1'b1);  // tag 1 was in way 0
        add_row(32'h0000_102c, 4'h1, 1'b0);  // set 1 untouched
        add_row(32'h0006_00b0, 4'hf, 1'b0);
    endtask

    // entered 2 ns after an edge, leaves 2 ns after the resp edge
    task automatic run_row(input int i);
        logic        saw_read;
        logic [31:0] miss_addr;
        int          waited;
        saw_read  = 1'b0;
        miss_addr = '0;
        waited    = 0;
        addr      = row_addr[i];
        rmask     = row_rmask[i];
        do begin
            @(posedge clk);
            #1;
            waited++;
            if (dfp_read && !saw_read) begin
                saw_read  = 1'b1;
                miss_addr = dfp_addr;
            end
        end while (!resp);
        check_miss("dfp_read", saw_read, row_miss[i]);
        compare_word("rdata", rdata, row_word[i]);
        if (saw_read) begin
            compare_word("dfp_addr", miss_addr, {row_addr[i][31:5], 5'b0});
        end
        if (!row_miss[i]) begin
            expect_latency("hit latency", waited, 1);
        end
        #1;
    endtask

    initial begin
        clk         = 1'b0;
        rst         = 1'b1;
        addr        = '0;
        rmask       = '0;
        cycle_count = 0;
        cycle_limit = 0;
        build_table();
        cycle_limit = row_addr.size() * 14 + 20;
        repeat (4) @(posedge clk);
        #2;
        rst = 1'b0;
        for (int i = 0; i < row_addr.size(); i++) begin
            run_row(i);
        end
        addr  = '0;
        rmask = '0;                          // no request open
        @(posedge clk);
        $display("Test passed");
        $finish;
    end

endmodule

`default_nettype wire

/* all.f */
src/cache_pkg.sv
src/cache_array.sv
src/cache_way.sv
src/cache_ctrl.sv
src/cache_hit_lru.sv
src/cache_top.sv
tests/mem_model.sv
tests/tb_cache.sv

/* run.sh */
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module tb_cache \
    -f all.f \
    -o sim_tb_cache

./obj_dir/sim_tb_cache
